// File: ws_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// shared types and constants for the WS2812 LED ring driver
// frame config layout, bit timing in 40 MHz cycles and ring geometry
// import into a module body, use scoped names in port lists
// ~~~~~~~~~~~~~~~~~~~~

package ws_pkg;

  // per-frame inputs
  typedef logic [11:0] led_mask_t;    // bit n lights LED n
  typedef logic [2:0]  colour_t;      // bit 0 green, bit 1 red, bit 2 blue
  typedef logic [7:0]  intensity_t;   // brightness byte, sent msb first

  // everything captured at frame_start
  typedef struct packed {
    led_mask_t  mask;       // lit LEDs
    colour_t    colour;     // enabled colours
    intensity_t intensity;  // byte sent for enabled colours
  } frame_cfg_t;

  // position counters used while walking a frame
  typedef logic [3:0] led_idx_t;      // LED 0..11
  typedef logic [1:0] colour_idx_t;   // 0 green, 1 red, 2 blue
  typedef logic [2:0] bit_idx_t;      // 7 down to 0

  // high/low phase counter inside one bit period
  typedef logic [5:0] phase_cnt_t;

  // ring geometry
  localparam int NUM_LEDS    = 12;    // LEDs on the ring
  localparam int NUM_COLOURS = 3;     // green, red, blue bytes per LED

  // bit waveform, cycles at 40 MHz (25 ns)
  localparam phase_cnt_t T1H = 6'd32; // one bit, high phase (800 ns)
  localparam phase_cnt_t T1L = 6'd18; // one bit, low phase (450 ns)
  localparam phase_cnt_t T0H = 6'd16; // zero bit, high phase (400 ns)
  localparam phase_cnt_t T0L = 6'd34; // zero bit, low phase (850 ns)

  // both symbols take the same time on the line
  localparam int BIT_CYCLES = 50;     // 1.25 us per bit

endpackage

// File: ws_bit_encoder.sv
// ~~~~~~~~~~~~~~~~~~~~
// WS2812 bit encoder, one high phase then one low phase per bit
// sends back to back periods while enc_run is high, bit_val sampled
// at each period start, bit_next pulses in the last low cycle
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module ws_bit_encoder (
  input  logic clk,
  input  logic rst,       // sync, active high
  input  logic enc_run,   // level, frame bits pending
  input  logic bit_val,   // current bit from the sequencer
  output logic led_dout,  // serial data line to the ring
  output logic bit_next   // pulse, period ends this cycle
);

  import ws_pkg::*;

  // the IDLE cycle in which enc_run is seen high is already
  // the first high cycle of the new period, so periods stay
  // back to back although the sequencer updates bit_val one
  // cycle after bit_next
  typedef enum logic {
    IDLE,
    SEND
  } enc_state_t;

  enc_state_t state;
  logic       in_high;    // high phase of the period
  logic       bit_one;    // bit sampled at period start
  phase_cnt_t cnt;        // cycles into the current phase
  phase_cnt_t high_last;  // last count of the high phase
  phase_cnt_t low_last;   // last count of the low phase

  assign high_last = (bit_one ? T1H : T0H) - phase_cnt_t'(1);
  assign low_last  = (bit_one ? T1L : T0L) - phase_cnt_t'(1);

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= IDLE;
      in_high <= 1'b0;
      cnt     <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (enc_run) begin               // period starts this cycle
            state   <= SEND;
            in_high <= 1'b1;
            cnt     <= phase_cnt_t'(1);     // cycle 0 was spent in IDLE
          end
        end
        SEND: begin
          if (in_high) begin
            if (cnt == high_last) begin    // switch to low phase
              in_high <= 1'b0;
              cnt     <= '0;
            end else begin
              cnt <= cnt + phase_cnt_t'(1);
            end
          end else if (cnt == low_last) begin
            state <= IDLE;                 // enc_run decides next cycle
            cnt   <= '0;
          end else begin
            cnt <= cnt + phase_cnt_t'(1);
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // symbol choice, held for the whole period
  always_ff @(posedge clk) begin
    if (state == IDLE && enc_run) begin
      bit_one <= bit_val;
    end
  end

  assign led_dout = (state == SEND) ? in_high : enc_run; // first cycle high when running
  assign bit_next = (state == SEND) && !in_high && (cnt == low_last);

endmodule

// File: ws_latch_timer.sv
// ~~~~~~~~~~~~~~~~~~~~
// latch gap timer, holds off the next frame after the last bit
// armed by gap_start, gap_end pulses in the RESET_CYCLES-th cycle after
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module ws_latch_timer #(
  parameter int unsigned RESET_CYCLES = 2000  // gap length, 1..2048 cycles
) (
  input  logic clk,
  input  logic rst,        // sync, active high
  input  logic gap_start,  // pulse, last bit just finished
  output logic gap_end     // pulse, last cycle of the gap
);

  // count down from the last index so gap_end is a plain compare
  localparam logic [10:0] GAP_LAST = 11'(RESET_CYCLES - 1);

  logic [10:0] gap_cnt;    // cycles left in the gap
  logic        gap_busy;   // gap in progress

  always_ff @(posedge clk) begin
    if (rst) begin
      gap_busy <= 1'b0;
      gap_cnt  <= '0;
    end else if (gap_start) begin
      gap_busy <= 1'b1;
      gap_cnt  <= GAP_LAST;               // first gap cycle is next
    end else if (gap_busy) begin
      if (gap_cnt == '0) begin
        gap_busy <= 1'b0;                 // done, wait for next arm
      end else begin
        gap_cnt <= gap_cnt - 11'd1;
      end
    end
  end

  assign gap_end = gap_busy && (gap_cnt == '0);

endmodule

// File: ws_frame_sequencer.sv
// ~~~~~~~~~~~~~~~~~~~~
// frame sequencer, captures the frame config and walks LED, colour
// and bit positions, feeding one bit at a time to the encoder
// starts the latch timer after bit 287 and restarts on its end
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module ws_frame_sequencer (
  input  logic               clk,
  input  logic               rst,          // sync, active high
  input  ws_pkg::frame_cfg_t cfg,          // live inputs, sampled per frame
  input  logic               bit_next,     // pulse from encoder
  input  logic               gap_end,      // pulse from latch timer
  output logic               enc_run,      // level, frame being sent
  output logic               bit_val,      // current bit on the line
  output logic               gap_start,    // pulse, start latch gap
  output logic               frame_start,  // pulse, cfg captured this cycle
  output logic               frame_done    // pulse, last gap cycle
);

  import ws_pkg::*;

  typedef enum logic [1:0] {
    LOAD,   // capture cfg, clear positions
    SEND,   // bits going out
    GAP     // line low, waiting on the timer
  } seq_state_t;

  localparam led_idx_t    LAST_LED = led_idx_t'(NUM_LEDS - 1);
  localparam colour_idx_t LAST_COL = colour_idx_t'(NUM_COLOURS - 1);
  localparam bit_idx_t    MSB_IDX  = 3'd7;          // bytes go msb first

  seq_state_t  state;
  frame_cfg_t  cfg_q;      // config of the frame on the line
  led_idx_t    led_idx;    // LED 0 goes first
  colour_idx_t col_idx;    // green, red, blue
  bit_idx_t    bit_idx;    // 7 down to 0
  logic        last_bit;   // bit 287 of the frame
  logic        capture;    // LOAD with frame_start up

  assign capture  = (state == LOAD) && frame_start;
  assign last_bit = (led_idx == LAST_LED) && (col_idx == LAST_COL) &&
                    (bit_idx == '0);

  // control path
  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= LOAD;
      frame_start <= 1'b0;
      led_idx     <= '0;
      col_idx     <= '0;
      bit_idx     <= MSB_IDX;
    end else begin
      frame_start <= 1'b0;                      // default, one-cycle pulse
      case (state)
        LOAD: begin
          led_idx <= '0;
          col_idx <= '0;
          bit_idx <= MSB_IDX;
          if (frame_start) begin
            state <= SEND;                      // cfg_q loads on this edge
          end else begin
            frame_start <= 1'b1;                // only after reset, one settle cycle
          end
        end
        SEND: begin
          if (bit_next) begin
            if (bit_idx != '0) begin
              bit_idx <= bit_idx - bit_idx_t'(1);
            end else begin
              bit_idx <= MSB_IDX;               // byte done
              if (col_idx != LAST_COL) begin
                col_idx <= col_idx + colour_idx_t'(1);
              end else begin
                col_idx <= '0;                  // LED done
                if (led_idx != LAST_LED) begin
                  led_idx <= led_idx + led_idx_t'(1);
                end else begin
                  state <= GAP;                 // bit 287 finished
                end
              end
            end
          end
        end
        GAP: begin
          if (gap_end) begin
            state       <= LOAD;
            frame_start <= 1'b1;                // next frame right after the gap
          end
        end
        default: state <= LOAD;
      endcase
    end
  end

  // frame config, held until the next capture
  always_ff @(posedge clk) begin
    if (capture) begin
      cfg_q <= cfg;
    end
  end

  // lit LED and enabled colour and intensity bit
  assign bit_val = cfg_q.mask[led_idx] & cfg_q.colour[col_idx] &
                   cfg_q.intensity[bit_idx];

  assign enc_run    = (state == SEND);              // drops after bit 287
  assign gap_start  = (state == SEND) && bit_next && last_bit;
  assign frame_done = (state == GAP) && gap_end;

endmodule

// File: led_ring_top.sv
// ~~~~~~~~~~~~~~~~~~~~
// top level of the 12 LED WS2812 ring driver, 40 MHz clock
// set RESET_CYCLES to the latch gap of the LED part in use
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module led_ring_top #(
  parameter int unsigned RESET_CYCLES = 2000  // latch gap, 50 us at 40 MHz
) (
  input  logic               clk,
  input  logic               rst,          // sync, active high
  input  ws_pkg::led_mask_t  led_mask,     // lit LEDs, level
  input  ws_pkg::colour_t    colour,       // green/red/blue enables, level
  input  ws_pkg::intensity_t intensity,    // brightness, level
  output logic               led_dout,     // data line to the ring
  output logic               frame_start,  // pulse, inputs captured
  output logic               frame_done    // pulse, end of latch gap
);

  import ws_pkg::*;

  frame_cfg_t cfg;         // inputs as one bundle
  logic       enc_run;     // sequencer to encoder
  logic       bit_val;
  logic       bit_next;    // encoder to sequencer
  logic       gap_start;   // sequencer to timer
  logic       gap_end;     // timer to sequencer

  assign cfg.mask      = led_mask;
  assign cfg.colour    = colour;
  assign cfg.intensity = intensity;

  ws_frame_sequencer i_ws_frame_sequencer (
    .clk         (clk),
    .rst         (rst),
    .cfg         (cfg),
    .bit_next    (bit_next),
    .gap_end     (gap_end),
    .enc_run     (enc_run),
    .bit_val     (bit_val),
    .gap_start   (gap_start),
    .frame_start (frame_start),
    .frame_done  (frame_done)
  );

  ws_bit_encoder i_ws_bit_encoder (
    .clk      (clk),
    .rst      (rst),
    .enc_run  (enc_run),
    .bit_val  (bit_val),
    .led_dout (led_dout),
    .bit_next (bit_next)
  );

  ws_latch_timer #(
    .RESET_CYCLES (RESET_CYCLES)
  ) i_ws_latch_timer (
    .clk       (clk),
    .rst       (rst),
    .gap_start (gap_start),
    .gap_end   (gap_end)
  );

endmodule

// File: tb_ws_decoder.sv
// ~~~~~~~~~~~~~~~~~~~~
// testbench monitor for the WS2812 data line
// measures each high pulse and the low time after it, reports one
// symbol per rising edge and flags low stretches longer than a bit
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module tb_ws_decoder (
  input  logic        clk,
  input  logic        rst,        // sync, active high
  input  logic        line,       // led_dout of the DUT
  output logic        sym_valid,  // pulse, previous symbol complete
  output logic        sym_bit,    // decoded value from the high width
  output logic [15:0] sym_hi,     // high cycles of the symbol
  output logic [15:0] sym_lo,     // low cycles after the high phase
  output logic        gap_valid,  // pulse, low stretch longer than a bit
  output logic [15:0] gap_len     // low cycles beyond the bit period
);

  import ws_pkg::*;

  // halfway between the two legal high widths
  localparam int HI_SPLIT = (int'(T0H) + int'(T1H)) / 2;

  logic        line_q;     // line one cycle back
  logic        seen_high;  // first rising edge has passed
  logic [15:0] hi_cnt;     // length of the current high phase
  logic [15:0] lo_cnt;     // length of the current low stretch

  always @(posedge clk) begin
    if (rst) begin
      line_q    <= 1'b0;
      seen_high <= 1'b0;
      hi_cnt    <= '0;
      lo_cnt    <= '0;
      sym_valid <= 1'b0;
      sym_bit   <= 1'b0;
      sym_hi    <= '0;
      sym_lo    <= '0;
      gap_valid <= 1'b0;
      gap_len   <= '0;
    end else begin
      sym_valid <= 1'b0;
      gap_valid <= 1'b0;
      line_q    <= line;
      if (line && !line_q) begin
        if (seen_high) begin                   // rising edge closes the last symbol
          sym_valid <= 1'b1;
          sym_bit   <= (hi_cnt > HI_SPLIT);
          sym_hi    <= hi_cnt;
          sym_lo    <= lo_cnt;
          if (lo_cnt > BIT_CYCLES) begin
            gap_valid <= 1'b1;
            gap_len   <= hi_cnt + lo_cnt - 16'(BIT_CYCLES);
          end
        end
        seen_high <= 1'b1;
        hi_cnt    <= 16'd1;
        lo_cnt    <= '0;
      end else if (line) begin
        hi_cnt <= hi_cnt + 16'd1;
      end else if (seen_high) begin
        lo_cnt <= lo_cnt + 16'd1;              // idle before the first pulse not counted
      end
    end
  end

endmodule

// File: tb_led_ring.sv
// ~~~~~~~~~~~~~~~~~~~~
// testbench for the WS2812 LED ring driver
// applies a table of frame inputs, one per frame, changing each entry
// halfway through the frame before, and checks every decoded bit,
// pulse width, latch gap and frame strobe against the expected stream
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module tb_led_ring;

  import ws_pkg::*;

  localparam int RESET_CYCLES = 64;
  localparam int NUM_ENTRIES  = 5;
  localparam int FRAME_BITS   = NUM_LEDS * 24;                  // 288
  localparam int FRAME_CYC    = FRAME_BITS * BIT_CYCLES;        // 14400
  localparam int TIMEOUT_CYC  = NUM_ENTRIES * (FRAME_CYC + RESET_CYCLES) + 1000;

  // one table row, inputs plus the count of one bits in the frame
  typedef struct packed {
    frame_cfg_t cfg;
    logic [8:0] ones;
  } stim_t;

  logic       clk = 1'b0;
  logic       rst;
  led_mask_t  led_mask;
  colour_t    colour;
  intensity_t intensity;
  logic       led_dout;
  logic       frame_start;
  logic       frame_done;

  logic        sym_valid;
  logic        sym_bit;
  logic [15:0] sym_hi;
  logic [15:0] sym_lo;
  logic        gap_valid;
  logic [15:0] gap_len;

  stim_t stim [NUM_ENTRIES];
  int    cyc       = 0;     // posedges since time 0
  int    n_starts  = 0;
  int    n_dones   = 0;
  int    n_bits    = 0;     // decoded bits so far
  int    start_cyc = 0;     // cycle of the last frame_start
  int    ones_cnt  = 0;     // one bits in the current frame
  logic  start_seen = 1'b0; // frame_start in the previous cycle
  logic  done_seen  = 1'b0; // frame_done in the previous cycle

  always #4 clk = ~clk;     // 8 ns period

  led_ring_top #(
    .RESET_CYCLES (RESET_CYCLES)
  ) i_led_ring_top (
    .clk         (clk),
    .rst         (rst),
    .led_mask    (led_mask),
    .colour      (colour),
    .intensity   (intensity),
    .led_dout    (led_dout),
    .frame_start (frame_start),
    .frame_done  (frame_done)
  );

  tb_ws_decoder i_tb_ws_decoder (
    .clk       (clk),
    .rst       (rst),
    .line      (led_dout),
    .sym_valid (sym_valid),
    .sym_bit   (sym_bit),
    .sym_hi    (sym_hi),
    .sym_lo    (sym_lo),
    .gap_valid (gap_valid),
    .gap_len   (gap_len)
  );

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
      $display("TEST FAIL");
      $fatal(1);
    end
  endtask

  // x^24 + x^23 + x^22 + x^17 + 1
  function automatic logic [23:0] lfsr_step(input logic [23:0] s);
    logic fb;
    fb = s[23] ^ s[22] ^ s[21] ^ s[16];
    return {s[22:0], fb};
  endfunction

  function automatic int popcount(input logic [11:0] v);
    int n;
    n = 0;
    for (int i = 0; i < 12; i++) n += v[i];
    return n;
  endfunction

  // bit j of a frame, 24 bits per LED, bytes green red blue, msb first
  function automatic logic expected_bit(input frame_cfg_t c, input int j);
    int          led;
    int          pos;
    logic [23:0] word;
    led  = j / 24;
    pos  = j % 24;
    word = '0;
    if (c.mask[led]) begin
      word[23:16] = c.colour[0] ? c.intensity : 8'h00;  // green
      word[15:8]  = c.colour[1] ? c.intensity : 8'h00;  // red
      word[7:0]   = c.colour[2] ? c.intensity : 8'h00;  // blue
    end
    return word[23 - pos];
  endfunction

  task automatic apply_entry(input int e);
    led_mask  = stim[e].cfg.mask;
    colour    = stim[e].cfg.colour;
    intensity = stim[e].cfg.intensity;
  endtask

  // frame strobes, line level around them, timeout
  always @(posedge clk) begin
    cyc++;
    if (cyc >= TIMEOUT_CYC) begin
      $display("timeout, frames did not finish within %0d cycles", TIMEOUT_CYC);
      $display("TEST FAIL");
      $fatal(1);
    end
    if (!rst) begin
      if (start_seen) check_value("led_dout after frame_start", led_dout, 1);
      if (n_starts > 0) check_value("frame_start", frame_start, done_seen);
      if (frame_start) begin
        check_value("led_dout in frame_start cycle", led_dout, 0);
        start_cyc = cyc;
        n_starts++;
      end
      if (frame_done) begin
        check_value("led_dout at frame_done", led_dout, 0);
        check_value("frame_done cycle", cyc - start_cyc, FRAME_CYC + RESET_CYCLES);
        n_dones++;
        check_value("frame_done count", n_dones, n_starts);
      end
      start_seen = frame_start;
      done_seen  = frame_done;
    end
  end

  // decoded bits against the table entry of their frame
  always @(posedge clk) begin : bit_check
    int   f;
    int   j;
    logic exp_bit;
    if (!rst && sym_valid && n_bits < NUM_ENTRIES * FRAME_BITS) begin
      f       = n_bits / FRAME_BITS;
      j       = n_bits % FRAME_BITS;
      exp_bit = expected_bit(stim[f].cfg, j);
      if (j == 0) ones_cnt = 0;
      check_value($sformatf("led_dout frame %0d bit %0d", f, j), sym_bit, exp_bit);
      check_value($sformatf("high width frame %0d bit %0d", f, j), sym_hi,
                  exp_bit ? T1H : T0H);
      check_value("gap after last bit", gap_valid, j == FRAME_BITS - 1);
      if (gap_valid) begin
        check_value("latch gap plus capture cycle", gap_len, RESET_CYCLES + 1);
      end else begin
        check_value("low width", sym_lo, exp_bit ? T1L : T0L);
      end
      ones_cnt += sym_bit;
      if (j == FRAME_BITS - 1) check_value("one bits in frame", ones_cnt, stim[f].ones);
      n_bits++;
    end
  end

  initial begin : main_seq
    logic [23:0] lfsr;
    logic [22:0] rnd;
    rst       = 1'b1;
    led_mask  = '0;
    colour    = '0;
    intensity = '0;
    // mask, colour (b,r,g), intensity, one bits
    stim[0] = '{cfg: '{12'h000, 3'b111, 8'hff}, ones: 9'd0};    // all off
    stim[1] = '{cfg: '{12'hfff, 3'b111, 8'hff}, ones: 9'd288};  // all white
    stim[2] = '{cfg: '{12'h020, 3'b010, 8'ha5}, ones: 9'd4};    // LED 5 red
    stim[3] = '{cfg: '{12'h555, 3'b101, 8'h3c}, ones: 9'd48};   // even LEDs green+blue
    lfsr = 24'd94996;
    rnd  = '0;
    for (int k = 0; k < 23; k++) begin
      lfsr = lfsr_step(lfsr);
      rnd  = {rnd[21:0], lfsr[23]};
    end
    stim[4].cfg  = rnd;
    stim[4].ones = 9'(popcount(stim[4].cfg.mask) * popcount(12'(stim[4].cfg.colour)) *
                      popcount(12'(stim[4].cfg.intensity)));
    apply_entry(0);
    repeat (16) begin
      @(negedge clk);
      check_value("led_dout in reset", led_dout, 0);
      check_value("frame_start in reset", frame_start, 0);
      check_value("frame_done in reset", frame_done, 0);
    end
    rst = 1'b0;
    @(negedge clk);                             // first cycle out of reset
    check_value("first frame_start", frame_start, 1);
    check_value("led_dout in first frame_start", led_dout, 0);
    @(negedge clk);
    check_value("first led_dout rise", led_dout, 1);
    check_value("frame_start width", frame_start, 0);
    for (int f = 0; f < NUM_ENTRIES; f++) begin
      wait (n_bits >= f * FRAME_BITS + FRAME_BITS / 2);  // halfway through frame f
      @(negedge clk);
      if (f + 1 < NUM_ENTRIES) apply_entry(f + 1);
    end
    wait (n_bits == NUM_ENTRIES * FRAME_BITS);
    @(negedge clk);
    check_value("frames done", n_dones, NUM_ENTRIES);
    check_value("frames started", n_starts, NUM_ENTRIES + 1);
    $display("TEST PASS");
    $finish;
  end

endmodule

// File: tb.f
ws_pkg.sv
ws_bit_encoder.sv
ws_latch_timer.sv
ws_frame_sequencer.sv
led_ring_top.sv
tb_ws_decoder.sv
tb_led_ring.sv
